// File: list.f
verilog/spw_timing_pkg.sv
verilog/spw_link_pkg.sv
verilog/spw_ctrl_sync.sv
verilog/spw_link_timer.sv
verilog/spw_link_fsm.sv
verilog/spw_link_status.sv
verilog/spw_link_top.sv
tests/tb_spw_link_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the link control testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_spw_link_top \
  -f list.f --Mdir "$build_dir" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

if grep -q "Checks failed" "$log_file"; then
  exit 1
fi
exit 0

// File: tests/tb_spw_link_top.sv
// needs Verilator --timing and --assert; delays assume the 100 ns clock of spw_timing_pkg
`timescale 1ns/1ps

module tb_spw_link_top;

  import spw_timing_pkg::*;
  import spw_link_pkg::*;

  // ------------------------------
  // constants and signals
  // ------------------------------
  localparam int reset_cycles   = 16;
  // ErrorReset to Run plus slack
  localparam int bringup_cycles = t_6p4_cycles + t_12p8_cycles + 40;
  localparam int limit_cycles   = reset_cycles + 7 * bringup_cycles + 2 * t_12p8_cycles;

  // selectors for watched outputs and driven events
  localparam int sel_rx_en  = 0;
  localparam int sel_tx_en  = 1;
  localparam int sel_nulls  = 2;
  localparam int sel_fcts   = 3;
  localparam int sel_nchars = 4;
  localparam int ev_null    = 0;
  localparam int ev_fct     = 1;
  localparam int ev_rx_err  = 2;
  localparam int ev_credit  = 3;
  localparam int ev_disable = 4;

  logic i_clk, i_reset_n, i_link_start, i_link_disable, i_auto_start;
  logic i_got_null, i_got_fct, i_got_n_char, i_got_time_code, i_rx_error, i_credit_error;
  logic o_link_reset_n, o_rx_en, o_tx_en, o_send_nulls, o_send_fcts;
  logic o_send_n_chars, o_send_time_codes, o_char_sequence_error, o_link_up, o_link_down;
  link_count_t o_link_drop_count;

  integer seed = 32'h7122_8c4f;
  int     error_count, check_count, test_count, test_errors;
  int     up_count, down_count, cse_count;
  string  test_name;

  spw_link_top uut (.*);

  initial
  begin
    i_clk = 1'b0;
    forever #(clk_period_ns / 2) i_clk = ~i_clk;
  end

  // strobe counters sample the settled value before each edge
  always @(posedge i_clk)
  begin
    up_count   <= up_count + int'(o_link_up);
    down_count <= down_count + int'(o_link_down);
    cse_count  <= cse_count + int'(o_char_sequence_error);
  end

  // ------------------------------
  // output table assertions
  // ------------------------------
  a_cse_single: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_char_sequence_error |=> !o_char_sequence_error)
  else
  begin
    error_count++;
    $display("o_char_sequence_error stayed high for more than one cycle");
  end
  a_order: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (!o_send_n_chars || o_send_fcts) && (!o_send_fcts || o_send_nulls) &&
    (!o_tx_en || (o_rx_en && o_link_reset_n)))
  else
  begin
    error_count++;
    $display("link enables out of order for a valid link state");
  end
  a_drop_step: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_link_down |-> (o_link_drop_count == $past(o_link_drop_count) + 8'd1))
  else
  begin
    error_count++;
    $display("[FAIL] o_link_drop_count 0x%0h did not step on o_link_down", o_link_drop_count);
  end

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp)
    else
    begin
      error_count++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic logic output_bit(input int sel);
    case (sel)
      sel_rx_en: return o_rx_en;
      sel_tx_en: return o_tx_en;
      sel_nulls: return o_send_nulls;
      sel_fcts:  return o_send_fcts;
      default:   return o_send_n_chars;
    endcase
  endfunction

  // polls at falling edges where outputs are settled
  task automatic wait_level(input string name, input int sel, input logic level,
                            input int max_cycles, output int cycles);
    cycles = 0;
    while (output_bit(sel) !== level && cycles < max_cycles)
    begin
      @(negedge i_clk);
      cycles++;
    end
    check_count++;
    assert (output_bit(sel) === level)
    else
    begin
      error_count++;
      $display("%s never reached %0d within %0d cycles", name, level, max_cycles);
    end
  endtask

  task automatic hold_low(input string name, input int sel, input int cycles);
    repeat (cycles)
    begin
      @(negedge i_clk);
      check_value(name, 32'(output_bit(sel)), 32'h0);
    end
  endtask

  task automatic check_all_low();
    check_value("o_link_reset_n", 32'(o_link_reset_n), 32'h0);
    check_value("o_rx_en", 32'(o_rx_en), 32'h0);
    check_value("o_tx_en", 32'(o_tx_en), 32'h0);
    check_value("o_send_nulls", 32'(o_send_nulls), 32'h0);
    check_value("o_send_fcts", 32'(o_send_fcts), 32'h0);
    check_value("o_send_n_chars", 32'(o_send_n_chars), 32'h0);
    check_value("o_send_time_codes", 32'(o_send_time_codes), 32'h0);
  endtask

  // one cycle strobe or a held disable level
  task automatic send_event(input int which);
    @(negedge i_clk);
    case (which)
      ev_null:   i_got_null = 1'b1;
      ev_fct:    i_got_fct = 1'b1;
      ev_rx_err: i_rx_error = 1'b1;
      ev_credit: i_credit_error = 1'b1;
      default:   i_link_disable = 1'b1;
    endcase
    @(negedge i_clk);
    {i_got_null, i_got_fct, i_rx_error, i_credit_error} = '0;
  endtask

  // walks from ErrorReset into Ready by elapsed time alone
  task automatic reach_ready();
    int cycles;
    wait_level("o_rx_en", sel_rx_en, 1'b1, t_6p4_cycles + 16, cycles);
    repeat (t_12p8_cycles + 4) @(negedge i_clk);
  endtask

  task automatic bring_up_link();
    int cycles;
    reach_ready();
    i_link_start = 1'b1;
    wait_level("o_send_nulls", sel_nulls, 1'b1, 8, cycles);
    send_event(ev_null);
    wait_level("o_send_fcts", sel_fcts, 1'b1, 8, cycles);
    send_event(ev_fct);
    wait_level("o_send_n_chars", sel_nchars, 1'b1, 8, cycles);
    i_link_start = 1'b0;
  endtask

  task automatic drop_link(input int which);
    int cycles;
    int down_start;
    link_count_t drop_start;
    down_start = down_count;
    drop_start = o_link_drop_count;
    send_event(which);
    wait_level("o_tx_en", sel_tx_en, 1'b0, 8, cycles);
    check_all_low();
    repeat (3) @(negedge i_clk);
    i_link_disable = 1'b0;
    check_value("o_link_down strobes", down_count - down_start, 32'h1);
    check_value("o_link_drop_count", 32'(o_link_drop_count), 32'(drop_start) + 32'h1);
  endtask

  task automatic open_test(input string name);
    test_name   = name;
    test_errors = error_count;
  endtask

  task automatic close_test();
    test_count++;
    if (error_count == test_errors)
      $display("test %0d %s: ok", test_count, test_name);
    else
      $display("test %0d %s: %0d errors", test_count, test_name, error_count - test_errors);
  endtask

  // ------------------------------
  // watchdog and test sequence
  // ------------------------------
  initial
  begin
    #(limit_cycles * clk_period_ns);
    $display("timeout after %0d cycles, the tests did not finish", limit_cycles);
    $display("Checks failed");
    $finish;
  end

  initial
  begin
    int cycles;
    int gap;
    int mark;
    {i_reset_n, i_link_start, i_link_disable, i_auto_start} = '0;
    {i_got_null, i_got_fct, i_got_n_char, i_got_time_code, i_rx_error, i_credit_error} = '0;
    repeat (reset_cycles) @(negedge i_clk);
    i_reset_n = 1'b1;

    open_test("reset and error recovery");
    check_all_low();
    wait_level("o_rx_en", sel_rx_en, 1'b1, t_6p4_cycles + 16, cycles);
    check_value("o_rx_en rise cycle", cycles >= t_6p4_cycles, 32'h1);
    hold_low("o_tx_en", sel_tx_en, t_12p8_cycles + 4);
    close_test();

    open_test("manual start to run");
    mark = up_count;
    i_link_start = 1'b1;
    wait_level("o_send_nulls", sel_nulls, 1'b1, 8, cycles);
    check_value("o_send_fcts", 32'(o_send_fcts), 32'h0);
    repeat (3)
    begin
      gap = 1 + ({$random(seed)} % 8);
      repeat (gap) @(negedge i_clk);
      send_event(ev_null);
    end
    check_value("o_send_fcts", 32'(o_send_fcts), 32'h1);
    check_value("o_send_n_chars", 32'(o_send_n_chars), 32'h0);
    check_value("o_send_time_codes", 32'(o_send_time_codes), 32'h0);
    send_event(ev_fct);
    wait_level("o_send_n_chars", sel_nchars, 1'b1, 8, cycles);
    check_value("o_send_time_codes", 32'(o_send_time_codes), 32'h1);
    i_link_start = 1'b0;
    repeat (4) @(negedge i_clk);
    check_value("o_link_up strobes", up_count - mark, 32'h1);
    close_test();

    open_test("link loss in run");
    drop_link(ev_disable);
    bring_up_link();
    drop_link(ev_rx_err);
    bring_up_link();
    drop_link(ev_credit);
    close_test();

    open_test("auto start waits for null");
    reach_ready();
    i_auto_start = 1'b1;
    hold_low("o_tx_en", sel_tx_en, 10 + ({$random(seed)} % 31));
    send_event(ev_null);
    wait_level("o_tx_en", sel_tx_en, 1'b1, 8, cycles);
    i_auto_start = 1'b0;
    send_event(ev_rx_err);
    wait_level("o_tx_en", sel_tx_en, 1'b0, 8, cycles);
    close_test();

    open_test("character sequence error");
    reach_ready();
    mark = cse_count;
    send_event(ev_fct);
    wait_level("o_rx_en", sel_rx_en, 1'b0, 8, cycles);
    repeat (3) @(negedge i_clk);
    check_value("o_char_sequence_error strobes", cse_count - mark, 32'h1);
    close_test();

    open_test("connect timeout");
    reach_ready();
    mark = cse_count;
    i_link_start = 1'b1;
    wait_level("o_tx_en", sel_tx_en, 1'b1, 8, cycles);
    i_link_start = 1'b0;
    wait_level("o_tx_en", sel_tx_en, 1'b0, t_12p8_cycles + 8, cycles);
    check_value("o_tx_en fall cycle", cycles >= t_12p8_cycles, 32'h1);
    check_value("o_char_sequence_error strobes", cse_count - mark, 32'h0);
    close_test();

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0)
    begin
      $display("All checks passed");
    end
    else
    begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: verilog/spw_link_top.sv
// single clock link control, receive strobes must already be in the i_clk domain
`timescale 1ns/1ps

module spw_link_top
(
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  // asynchronous control levels
  input  logic                      i_link_start,
  input  logic                      i_link_disable,
  input  logic                      i_auto_start,
  // receiver and transmitter strobes
  input  logic                      i_got_null,
  input  logic                      i_got_fct,
  input  logic                      i_got_n_char,
  input  logic                      i_got_time_code,
  input  logic                      i_rx_error,
  input  logic                      i_credit_error,
  // link controls
  output logic                      o_link_reset_n,
  output logic                      o_rx_en,
  output logic                      o_tx_en,
  output logic                      o_send_nulls,
  output logic                      o_send_fcts,
  output logic                      o_send_n_chars,
  output logic                      o_send_time_codes,
  output logic                      o_char_sequence_error,
  // link status
  output logic                      o_link_up,
  output logic                      o_link_down,
  output spw_link_pkg::link_count_t o_link_drop_count
);

  // synchronized control levels
  logic link_start_s;
  logic link_disable_s;
  logic auto_start_s;

  // timer handshake and run level
  logic timer_restart;
  logic after_6p4;
  logic after_12p8;
  logic run_state;

  // ------------------------------
  // control level synchronizer
  // ------------------------------
  spw_ctrl_sync u_ctrl_sync
  (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_link_start   (i_link_start),
    .i_link_disable (i_link_disable),
    .i_auto_start   (i_auto_start),
    .o_link_start   (link_start_s),
    .o_link_disable (link_disable_s),
    .o_auto_start   (auto_start_s)
  );

  // ------------------------------
  // link delay timer
  // ------------------------------
  spw_link_timer u_link_timer
  (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_restart    (timer_restart),
    .o_after_6p4  (after_6p4),
    .o_after_12p8 (after_12p8)
  );

  // ------------------------------
  // link state machine
  // ------------------------------
  spw_link_fsm u_link_fsm
  (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .i_link_start          (link_start_s),
    .i_link_disable        (link_disable_s),
    .i_auto_start          (auto_start_s),
    .i_got_null            (i_got_null),
    .i_got_fct             (i_got_fct),
    .i_got_n_char          (i_got_n_char),
    .i_got_time_code       (i_got_time_code),
    .i_rx_error            (i_rx_error),
    .i_credit_error        (i_credit_error),
    .i_after_6p4           (after_6p4),
    .i_after_12p8          (after_12p8),
    .o_timer_restart       (timer_restart),
    .o_run_state           (run_state),
    .o_link_reset_n        (o_link_reset_n),
    .o_rx_en               (o_rx_en),
    .o_tx_en               (o_tx_en),
    .o_send_nulls          (o_send_nulls),
    .o_send_fcts           (o_send_fcts),
    .o_send_n_chars        (o_send_n_chars),
    .o_send_time_codes     (o_send_time_codes),
    .o_char_sequence_error (o_char_sequence_error)
  );

  // ------------------------------
  // link status
  // ------------------------------
  spw_link_status u_link_status
  (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_run_state       (run_state),
    .o_link_up         (o_link_up),
    .o_link_down       (o_link_down),
    .o_link_drop_count (o_link_drop_count)
  );

endmodule

// File: verilog/spw_link_status.sv
// strobes lag the run level by one cycle and the drop count sticks at its maximum
`timescale 1ns/1ps

module spw_link_status
(
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  // high while the link is in Run
  input  logic                      i_run_state,
  // single cycle edge strobes
  output logic                      o_link_up,
  output logic                      o_link_down,
  // Run exits since reset
  output spw_link_pkg::link_count_t o_link_drop_count
);

  import spw_link_pkg::*;

  // run level one cycle back
  logic run_d;

  // ------------------------------
  // edge strobes
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n)
  begin
    if (!i_reset_n)
    begin
      run_d       <= 1'b0;
      o_link_up   <= 1'b0;
      o_link_down <= 1'b0;
    end
    else
    begin
      run_d       <= i_run_state;
      o_link_up   <= i_run_state & ~run_d;
      o_link_down <= ~i_run_state & run_d;
    end
  end

  // ------------------------------
  // drop counter
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n)
  begin
    if (!i_reset_n)
    begin
      o_link_drop_count <= '0;
    end
    else if (~i_run_state && run_d && (o_link_drop_count != link_count_max))
    begin
      // steps on the same edge that raises o_link_down
      o_link_drop_count <= o_link_drop_count + link_count_t'(1);
    end
  end

endmodule

// File: verilog/spw_link_fsm.sv
// receive strobes must be single i_clk pulses and control levels must already be synchronized
`timescale 1ns/1ps

module spw_link_fsm
(
  input  logic i_clk,
  input  logic i_reset_n,
  // synchronized control levels
  input  logic i_link_start,
  input  logic i_link_disable,
  input  logic i_auto_start,
  // receiver event strobes
  input  logic i_got_null,
  input  logic i_got_fct,
  input  logic i_got_n_char,
  input  logic i_got_time_code,
  input  logic i_rx_error,
  // transmitter credit overflow strobe
  input  logic i_credit_error,
  // delay flags from the timer
  input  logic i_after_6p4,
  input  logic i_after_12p8,
  // timer clear and run level for status
  output logic o_timer_restart,
  output logic o_run_state,
  // link controls
  output logic o_link_reset_n,
  output logic o_rx_en,
  output logic o_tx_en,
  output logic o_send_nulls,
  output logic o_send_fcts,
  output logic o_send_n_chars,
  output logic o_send_time_codes,
  output logic o_char_sequence_error
);

  import spw_link_pkg::*;

  link_state_t state_q;
  link_state_t state_next;

  // gotNULL condition
  logic got_null_q;
  // latch or a NULL arriving right now
  logic got_null_w;

  // unexpected character for the current state
  logic seq_err;
  // any other reason to fall back to ErrorReset
  logic abort;
  // sequence error that actually causes the fall back
  logic cse_next;

  assign got_null_w = got_null_q | i_got_null;

  // ------------------------------
  // next state
  // ------------------------------
  always_comb
  begin
    state_next = state_q;
    seq_err    = 1'b0;
    abort      = 1'b0;
    case (state_q)
      st_error_reset:
      begin
        // receive error keeps us here, delay restarts only on a state change
        if (i_after_6p4 && !i_rx_error)
        begin
          state_next = st_error_wait;
        end
      end
      st_error_wait:
      begin
        // only NULLs are allowed while waiting
        seq_err = i_got_fct | i_got_n_char | i_got_time_code;
        abort   = i_rx_error | i_credit_error;
        if (abort || seq_err)
        begin
          state_next = st_error_reset;
        end
        else if (i_after_12p8)
        begin
          state_next = st_ready;
        end
      end
      st_ready:
      begin
        seq_err = i_got_fct | i_got_n_char | i_got_time_code;
        abort   = i_rx_error | i_credit_error;
        if (abort || seq_err)
        begin
          state_next = st_error_reset;
        end
        else if (i_link_start || (i_auto_start && got_null_w))
        begin
          // auto start waits for the far end to send a NULL
          state_next = st_started;
        end
      end
      st_started:
      begin
        seq_err = i_got_fct | i_got_n_char | i_got_time_code;
        // no NULL within 12.8 us is a connect timeout
        abort   = i_rx_error | i_credit_error | i_link_disable | i_after_12p8;
        if (abort || seq_err)
        begin
          state_next = st_error_reset;
        end
        else if (got_null_w)
        begin
          state_next = st_connecting;
        end
      end
      st_connecting:
      begin
        // FCTs are now expected, data and time codes still not
        seq_err = i_got_n_char | i_got_time_code;
        abort   = i_rx_error | i_credit_error | i_link_disable | i_after_12p8;
        if (abort || seq_err)
        begin
          state_next = st_error_reset;
        end
        else if (i_got_fct)
        begin
          state_next = st_run;
        end
      end
      st_run:
      begin
        abort = i_rx_error | i_credit_error | i_link_disable;
        if (abort)
        begin
          state_next = st_error_reset;
        end
      end
      default:
      begin
        state_next = st_error_reset;
      end
    endcase
  end

  // other errors take priority in the report
  assign cse_next = seq_err & ~abort;

  // counter clears on the same edge the state changes
  assign o_timer_restart = (state_next != state_q);

  // ------------------------------
  // state, gotNULL and outputs
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n)
  begin
    if (!i_reset_n)
    begin
      state_q               <= st_error_reset;
      got_null_q            <= 1'b0;
      o_run_state           <= 1'b0;
      o_link_reset_n        <= 1'b0;
      o_rx_en               <= 1'b0;
      o_tx_en               <= 1'b0;
      o_send_nulls          <= 1'b0;
      o_send_fcts           <= 1'b0;
      o_send_n_chars        <= 1'b0;
      o_send_time_codes     <= 1'b0;
      o_char_sequence_error <= 1'b0;
    end
    else
    begin
      state_q <= state_next;

      // NULLs count in ErrorWait, Ready and Started only
      if (state_q == st_error_reset)
      begin
        got_null_q <= 1'b0;
      end
      else if (i_got_null &&
               (state_q == st_error_wait || state_q == st_ready || state_q == st_started))
      begin
        got_null_q <= 1'b1;
      end

      // outputs follow the next state so they are glitch free
      o_link_reset_n    <= (state_next != st_error_reset);
      o_rx_en           <= (state_next != st_error_reset);
      o_tx_en           <= (state_next == st_started) || (state_next == st_connecting) ||
                           (state_next == st_run);
      o_send_nulls      <= (state_next == st_started) || (state_next == st_connecting) ||
                           (state_next == st_run);
      o_send_fcts       <= (state_next == st_connecting) || (state_next == st_run);
      o_send_n_chars    <= (state_next == st_run);
      o_send_time_codes <= (state_next == st_run);
      o_run_state       <= (state_next == st_run);

      // single cycle, the state has left by the next edge
      o_char_sequence_error <= cse_next;
    end
  end

endmodule

// File: verilog/spw_link_timer.sv
// one shared counter serves both delays, so only the delay since the last restart is known
`timescale 1ns/1ps

module spw_link_timer
(
  input  logic i_clk,
  input  logic i_reset_n,
  // clears the count, one cycle wide
  input  logic i_restart,
  // levels that hold until the next restart
  output logic o_after_6p4,
  output logic o_after_12p8
);

  import spw_timing_pkg::*;

  // ------------------------------
  // delay counter
  // ------------------------------
  // cycles since reset or the last restart
  timer_count_t count_q;

  // count limit as a counter value
  localparam timer_count_t count_6p4  = timer_count_t'(t_6p4_cycles);
  localparam timer_count_t count_12p8 = timer_count_t'(t_12p8_cycles);

  always_ff @(posedge i_clk or negedge i_reset_n)
  begin
    if (!i_reset_n)
    begin
      // reset also starts the ErrorReset delay
      count_q <= '0;
    end
    else if (i_restart)
    begin
      count_q <= '0;
    end
    else if (count_q != count_12p8)
    begin
      // stops at the longer delay so the flags stay up
      count_q <= count_q + timer_count_t'(1);
    end
  end

  // ------------------------------
  // delay flags
  // ------------------------------
  // 6.4 us passed, stays high past 12.8 us too
  assign o_after_6p4  = (count_q >= count_6p4);

  // counter parks at this value
  assign o_after_12p8 = (count_q == count_12p8);

endmodule

// File: verilog/spw_ctrl_sync.sv
// control levels are seen two i_clk cycles late and must stay stable for at least two cycles
`timescale 1ns/1ps

module spw_ctrl_sync
(
  input  logic i_clk,
  input  logic i_reset_n,
  // asynchronous levels from the user side
  input  logic i_link_start,
  input  logic i_link_disable,
  input  logic i_auto_start,
  // same levels in the i_clk domain
  output logic o_link_start,
  output logic o_link_disable,
  output logic o_auto_start
);

  // first stage may go metastable
  logic [2:0] meta_q;
  // second stage is safe to read
  logic [2:0] sync_q;

  always_ff @(posedge i_clk or negedge i_reset_n)
  begin
    if (!i_reset_n)
    begin
      meta_q <= '0;
      sync_q <= '0;
    end
    else
    begin
      // bit order is start, disable, auto start
      meta_q <= {i_link_start, i_link_disable, i_auto_start};
      sync_q <= meta_q;
    end
  end

  assign o_link_start   = sync_q[2];
  assign o_link_disable = sync_q[1];
  assign o_auto_start   = sync_q[0];

endmodule

// File: verilog/spw_link_pkg.sv
// state encoding is fixed at 3 bits and the drop count saturates at 8 bits
package spw_link_pkg;

  // ------------------------------
  // link state machine
  // ------------------------------
  // ECSS-E-ST-50-12C link states, ErrorReset is the reset state
  typedef enum logic [2:0] {
    st_error_reset = 3'd0,
    st_error_wait  = 3'd1,
    st_ready       = 3'd2,
    st_started     = 3'd3,
    st_connecting  = 3'd4,
    st_run         = 3'd5
  } link_state_t;

  // ------------------------------
  // link status
  // ------------------------------
  // number of Run exits seen since reset
  typedef logic [7:0] link_count_t;

  // count holds here instead of wrapping
  localparam link_count_t link_count_max = link_count_t'(255);

endpackage

// File: verilog/spw_timing_pkg.sv
// link delays assume a 10 MHz i_clk, so any other clock rate needs new cycle counts here
package spw_timing_pkg;

  // ------------------------------
  // clock rate
  // ------------------------------
  // period of i_clk in ns that the cycle counts below are based on
  localparam int clk_period_ns = 100;

  // ------------------------------
  // link delays in i_clk cycles
  // ------------------------------
  // ErrorReset dwell time, 6.4 us nominal
  localparam int t_6p4_cycles  = 64;
  // ErrorWait dwell and Started/Connecting timeout, 12.8 us nominal
  localparam int t_12p8_cycles = 128;

  // delay counter, wide enough for the longer delay
  typedef logic [7:0] timer_count_t;

endpackage
